// File: axi_lite_mem.f
+incdir+hdl
hdl/axi_lite_mem_pkg.sv
hdl/axi_lite_to_axi.sv
hdl/axi_addr_decode.sv
hdl/axi_mem_ctrl.sv
hdl/axi_mem_cfg.sv
hdl/axi_lite_mem_top.sv
bench/tb_axi_lite_mem.sv

// File: Makefile
BIN  := obj_dir/Vtb_axi_lite_mem
SRCS := $(shell grep -v '^+' axi_lite_mem.f) hdl/axi_lite_mem_config.svh

.PHONY: all run clean

all: run

$(BIN): axi_lite_mem.f $(SRCS)
	verilator --binary --timescale 1ns/100ps -f axi_lite_mem.f --top-module tb_axi_lite_mem

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: bench/tb_axi_lite_mem.sv
// AXI-Lite memory testbench
`timescale 1ns/100ps
`include "axi_lite_mem_config.svh"

module tb_axi_lite_mem;
  import axi_lite_mem_pkg::*;

  // configuration block base and register offsets
  localparam addr_t CFG_BASE = addr_t'(1) << `CFG_SEL_BIT;
  localparam addr_t OFS_WAIT = 32'h0;
  localparam addr_t OFS_PROT = 32'h4;
  localparam addr_t OFS_WCNT = 32'h8;
  // longest any single wait may take in cycles
  localparam int WAIT_LIMIT = 200;

  logic       clk;
  logic       arst_n;
  lite_req_t  lite_req;
  lite_resp_t lite_resp;

  // shadow of memory contents and configuration
  data_t sh_mem [`MEM_WORDS];
  int    sh_wait;
  int    sh_prot;
  int    sh_wcnt;

  // error counts per kind of check
  int err_resp;
  int err_data;
  int err_lat;
  int err_proto;

  axi_lite_mem_top u_axi_lite_mem_top (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .lite_req_i  (lite_req),
    .lite_resp_o (lite_resp)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s after %0d cycles", what, WAIT_LIMIT);
    $display("errors: resp %0d data %0d latency %0d protocol %0d",
             err_resp, err_data, err_lat, err_proto);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e got);
    if (got !== exp) begin
      err_resp++;
      $display("error %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t got);
    if (got !== exp) begin
      err_data++;
      $display("error %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int got);
    if (got != exp) begin
      err_lat++;
      $display("error %s latency expected %h got %h", name, exp, got);
    end
  endtask

  // one write with b_ready held low for hold cycles once b_valid is up
  task automatic lite_write(input addr_t addr, input data_t data, input strb_t strb,
                            input int hold, output axi_resp_e resp, output int lat);
    int n;
    @(posedge clk);
    lite_req.aw.addr  <= addr;
    lite_req.aw.prot  <= 3'd0;
    lite_req.w.data   <= data;
    lite_req.w.strb   <= strb;
    lite_req.aw_valid <= 1'b1;
    lite_req.w_valid  <= 1'b1;
    // AW and W are taken in the same cycle
    n = 0;
    @(negedge clk);
    while (!(lite_resp.aw_ready && lite_resp.w_ready)) begin
      // one ready without the other breaks the paired accept
      if (lite_resp.aw_ready || lite_resp.w_ready) begin
        err_proto++;
        $display("aw_ready and w_ready were not raised in the same cycle");
      end
      n++;
      if (n > WAIT_LIMIT) report_timeout("aw_ready and w_ready");
      @(negedge clk);
    end
    @(posedge clk);
    lite_req.aw_valid <= 1'b0;
    lite_req.w_valid  <= 1'b0;
    // cycles from acceptance to b_valid
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      if (lat > WAIT_LIMIT) report_timeout("b_valid");
    end while (!lite_resp.b_valid);
    resp = lite_resp.b.resp;
    // response frozen under back-pressure
    repeat (hold) begin
      @(negedge clk);
      if (!lite_resp.b_valid || lite_resp.b.resp !== resp) begin
        err_proto++;
        $display("b response dropped or changed while b_ready was low");
      end
    end
    @(posedge clk);
    lite_req.b_ready <= 1'b1;
    // b_valid is up so the beat goes on this edge
    @(posedge clk);
    lite_req.b_ready <= 1'b0;
  endtask

  // one read with r_ready held low for hold cycles once r_valid is up
  task automatic lite_read(input addr_t addr, input int hold, output data_t data,
                           output axi_resp_e resp, output int lat);
    int n;
    @(posedge clk);
    lite_req.ar.addr  <= addr;
    lite_req.ar.prot  <= 3'd0;
    lite_req.ar_valid <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!lite_resp.ar_ready) begin
      n++;
      if (n > WAIT_LIMIT) report_timeout("ar_ready");
      @(negedge clk);
    end
    @(posedge clk);
    lite_req.ar_valid <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      if (lat > WAIT_LIMIT) report_timeout("r_valid");
    end while (!lite_resp.r_valid);
    data = lite_resp.r.data;
    resp = lite_resp.r.resp;
    repeat (hold) begin
      @(negedge clk);
      if (!lite_resp.r_valid || lite_resp.r.data !== data || lite_resp.r.resp !== resp) begin
        err_proto++;
        $display("r response dropped or changed while r_ready was low");
      end
    end
    @(posedge clk);
    lite_req.r_ready <= 1'b1;
    @(posedge clk);
    lite_req.r_ready <= 1'b0;
  endtask

  // strobed bytes of data over old
  function automatic data_t merge_bytes(input data_t old, input data_t data, input strb_t strb);
    data_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old & ~mask) | (data & mask);
  endfunction

  // decode error is checked before protection
  function automatic axi_resp_e exp_write_resp(input addr_t addr);
    addr_t idx;
    idx = addr >> 2;
    if (idx >= `MEM_WORDS) return RESP_DECERR;
    if (idx >= addr_t'(sh_prot)) return RESP_SLVERR;
    return RESP_OKAY;
  endfunction

  task automatic mem_write(input addr_t addr, input data_t data, input strb_t strb,
                           input int hold);
    axi_resp_e exp;
    axi_resp_e got;
    int        lat;
    addr_t     idx;
    exp = exp_write_resp(addr);
    lite_write(addr, data, strb, hold, got, lat);
    check_resp("b.resp", exp, got);
    check_latency("b_valid", sh_wait + 1, lat);
    if (exp == RESP_OKAY) begin
      idx = addr >> 2;
      sh_mem[idx[`MEM_IDX_W-1:0]] = merge_bytes(sh_mem[idx[`MEM_IDX_W-1:0]], data, strb);
      sh_wcnt++;
    end
  endtask

  task automatic mem_read(input addr_t addr, input int hold);
    axi_resp_e exp_resp;
    axi_resp_e got_resp;
    data_t     exp_data;
    data_t     got_data;
    int        lat;
    addr_t     idx;
    idx = addr >> 2;
    // words past the end read as zero
    if (idx >= `MEM_WORDS) begin
      exp_resp = RESP_DECERR;
      exp_data = '0;
    end else begin
      exp_resp = RESP_OKAY;
      exp_data = sh_mem[idx[`MEM_IDX_W-1:0]];
    end
    lite_read(addr, hold, got_data, got_resp, lat);
    check_resp("r.resp", exp_resp, got_resp);
    check_data("r.data", exp_data, got_data);
    check_latency("r_valid", sh_wait + 1, lat);
  endtask

  task automatic cfg_write(input addr_t ofs, input data_t data, input axi_resp_e exp);
    axi_resp_e got;
    int        lat;
    lite_write(CFG_BASE | ofs, data, 4'hf, 0, got, lat);
    check_resp("b.resp", exp, got);
    // config block answers one cycle after acceptance
    check_latency("b_valid", 1, lat);
    if (exp == RESP_OKAY && ofs == OFS_WAIT) sh_wait = int'(data);
    if (exp == RESP_OKAY && ofs == OFS_PROT) sh_prot = int'(data);
  endtask

  task automatic cfg_read(input addr_t ofs, input data_t exp);
    axi_resp_e got_resp;
    data_t     got_data;
    int        lat;
    lite_read(CFG_BASE | ofs, 0, got_data, got_resp, lat);
    check_resp("r.resp", RESP_OKAY, got_resp);
    check_data("r.data", exp, got_data);
    check_latency("r_valid", 1, lat);
  endtask

  // reset values then read back of the settings and the read-only counter
  task automatic config_regs();
    cfg_read(OFS_WAIT, data_t'(`CFG_WAIT_RESET));
    cfg_read(OFS_PROT, data_t'(`MEM_WORDS));
    cfg_read(OFS_WCNT, '0);
    cfg_write(OFS_WAIT, 32'd5, RESP_OKAY);
    cfg_write(OFS_PROT, 32'd200, RESP_OKAY);
    cfg_read(OFS_WAIT, 32'd5);
    cfg_read(OFS_PROT, 32'd200);
    cfg_write(OFS_WCNT, 32'h1234, RESP_SLVERR);
    // unknown offset
    cfg_write(32'h10, 32'h1, RESP_SLVERR);
    cfg_read(OFS_WCNT, '0);
    cfg_write(OFS_WAIT, data_t'(`CFG_WAIT_RESET), RESP_OKAY);
    cfg_write(OFS_PROT, data_t'(`MEM_WORDS), RESP_OKAY);
  endtask

  task automatic random_rw();
    addr_t a;
    // full-width fill so every word is known
    for (int i = 0; i < `MEM_WORDS; i++) begin
      a = addr_t'(i) << 2;
      mem_write(a, {~a[15:0], a[15:0]}, 4'hf, 0);
    end
    repeat (64) begin
      a = addr_t'($urandom_range(0, `MEM_WORDS - 1)) << 2;
      mem_write(a, $urandom(), strb_t'($urandom_range(0, 15)), 0);
    end
    for (int i = 0; i < `MEM_WORDS; i++) begin
      mem_read(addr_t'(i) << 2, 0);
    end
  endtask

  task automatic write_protect();
    int idx_list [6] = '{0, 100, 191, 192, 200, 255};
    cfg_write(OFS_PROT, 32'd192, RESP_OKAY);
    foreach (idx_list[k]) begin
      mem_write(addr_t'(idx_list[k]) << 2, $urandom(), 4'hf, 0);
      mem_read(addr_t'(idx_list[k]) << 2, 0);
    end
    cfg_write(OFS_PROT, data_t'(`MEM_WORDS), RESP_OKAY);
  endtask

  task automatic decode_errors();
    // past the end, top of the window and beyond the window
    addr_t bad [3] = '{32'h0000_0400, 32'h0000_0ffc, 32'h0000_2000};
    foreach (bad[k]) begin
      mem_write(bad[k], $urandom(), 4'hf, 0);
      mem_read(bad[k], 0);
    end
  endtask

  task automatic write_count();
    cfg_read(OFS_WCNT, data_t'(sh_wcnt));
  endtask

  task automatic back_pressure();
    int    ws_list [4] = '{0, 1, 3, 7};
    addr_t a;
    foreach (ws_list[k]) begin
      cfg_write(OFS_WAIT, data_t'(ws_list[k]), RESP_OKAY);
      a = addr_t'($urandom_range(0, `MEM_WORDS - 1)) << 2;
      mem_write(a, $urandom(), strb_t'($urandom_range(1, 15)), $urandom_range(1, 8));
      mem_read(a, $urandom_range(1, 8));
    end
    cfg_write(OFS_WAIT, data_t'(`CFG_WAIT_RESET), RESP_OKAY);
  endtask

  initial begin
    void'($urandom(32'h4eff));
    lite_req  <= '0;
    arst_n    <= 1'b0;
    sh_wait   = `CFG_WAIT_RESET;
    sh_prot   = `MEM_WORDS;
    sh_wcnt   = 0;
    err_resp  = 0;
    err_data  = 0;
    err_lat   = 0;
    err_proto = 0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    config_regs();
    random_rw();
    write_protect();
    decode_errors();
    write_count();
    back_pressure();
    write_count();
    $display("errors: resp %0d data %0d latency %0d protocol %0d",
             err_resp, err_data, err_lat, err_proto);
    if (err_resp + err_data + err_lat + err_proto == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/axi_lite_mem_top.sv
// AXI-Lite memory subsystem top
`timescale 1ns/100ps

module axi_lite_mem_top (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // external AXI4-Lite master
  input  axi_lite_mem_pkg::lite_req_t  lite_req_i,
  output axi_lite_mem_pkg::lite_resp_t lite_resp_o
);
  import axi_lite_mem_pkg::*;

  // widened bus between adapter and decoder
  axi_req_t  axi_req;
  axi_resp_t axi_resp;
  // per-target buses
  axi_req_t  mem_req, cfg_req;
  axi_resp_t mem_resp, cfg_resp;
  // sideband between config block and controller
  cfg_t      cfg;
  logic      wr_done;

  axi_lite_to_axi u_axi_lite_to_axi (
    .slv_req_lite_i  (lite_req_i),
    .slv_resp_lite_o (lite_resp_o),
    .mst_req_o       (axi_req),
    .mst_resp_i      (axi_resp)
  );

  axi_addr_decode u_axi_addr_decode (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .slv_req_i  (axi_req),
    .slv_resp_o (axi_resp),
    .mem_req_o  (mem_req),
    .mem_resp_i (mem_resp),
    .cfg_req_o  (cfg_req),
    .cfg_resp_i (cfg_resp)
  );

  axi_mem_ctrl u_axi_mem_ctrl (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (mem_req),
    .resp_o    (mem_resp),
    .cfg_i     (cfg),
    .wr_done_o (wr_done)
  );

  axi_mem_cfg u_axi_mem_cfg (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (cfg_req),
    .resp_o    (cfg_resp),
    .cfg_o     (cfg),
    .wr_done_i (wr_done)
  );

endmodule

// File: hdl/axi_mem_cfg.sv
// AXI4 configuration register block
`timescale 1ns/100ps
`include "axi_lite_mem_config.svh"

module axi_mem_cfg (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  axi_lite_mem_pkg::axi_req_t  req_i,
  output axi_lite_mem_pkg::axi_resp_t resp_o,
  output axi_lite_mem_pkg::cfg_t      cfg_o,
  // completed memory write
  input  logic                        wr_done_i
);
  import axi_lite_mem_pkg::*;

  // register offsets inside the block
  typedef enum logic [11:0] {
    REG_WAIT = 12'h000,
    REG_PROT = 12'h004,
    REG_WCNT = 12'h008
  } cfg_reg_e;

  logic [`WAIT_W-1:0]  wait_q;
  logic [`MEM_IDX_W:0] prot_q;
  data_t               wcnt_q;
  logic                b_valid_q, r_valid_q;
  axi_resp_e           bresp_q, rresp_q;
  data_t               rdata_q;
  logic [3:0]          bid_q, rid_q;

  logic      idle, wr_go, rd_go;
  logic      wr_wait, wr_prot;
  axi_resp_e rd_resp;
  data_t     rd_data;

  assign idle  = ~b_valid_q & ~r_valid_q;
  assign wr_go = idle & req_i.aw_valid & req_i.w_valid;
  assign rd_go = idle & req_i.ar_valid & ~wr_go;

  // only the two settings are writable
  assign wr_wait = req_i.aw.addr[11:0] == REG_WAIT;
  assign wr_prot = req_i.aw.addr[11:0] == REG_PROT;

  // read mux, unknown offsets give zero with an error
  always_comb begin
    rd_resp = RESP_OKAY;
    case (req_i.ar.addr[11:0])
      REG_WAIT: rd_data = data_t'(wait_q);
      REG_PROT: rd_data = data_t'(prot_q);
      REG_WCNT: rd_data = wcnt_q;
      default: begin
        rd_data = '0;
        rd_resp = RESP_SLVERR;
      end
    endcase
  end

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = wr_go;
    resp_o.w_ready  = wr_go;
    resp_o.ar_ready = rd_go;
    resp_o.b        = '{id: bid_q, resp: bresp_q};
    resp_o.b_valid  = b_valid_q;
    resp_o.r        = '{id: rid_q, data: rdata_q, resp: rresp_q, last: 1'b1};
    resp_o.r_valid  = r_valid_q;
  end

  assign cfg_o = '{wait_states: wait_q, protect_base: prot_q};

  // settings, counter and response valids
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_q    <= `WAIT_W'(`CFG_WAIT_RESET);
      prot_q    <= (`MEM_IDX_W+1)'(`CFG_PROT_RESET);
      wcnt_q    <= '0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_go && wr_wait) begin
        wait_q <= req_i.w.data[`WAIT_W-1:0];
      end
      if (wr_go && wr_prot) begin
        prot_q <= req_i.w.data[`MEM_IDX_W:0];
      end
      // counts memory writes only, never its own
      if (wr_done_i) begin
        wcnt_q <= wcnt_q + 1'b1;
      end
      // response one cycle after acceptance, held under back-pressure
      if (wr_go) begin
        b_valid_q <= 1'b1;
      end else if (req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_go) begin
        r_valid_q <= 1'b1;
      end else if (req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // response payload captured at acceptance
  always_ff @(posedge clk_i) begin
    if (wr_go) begin
      bid_q   <= req_i.aw.id;
      bresp_q <= (wr_wait || wr_prot) ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_go) begin
      rid_q   <= req_i.ar.id;
      rresp_q <= rd_resp;
      rdata_q <= rd_data;
    end
  end

endmodule

// File: hdl/axi_mem_ctrl.sv
// AXI4 single-beat memory controller
`timescale 1ns/100ps
`include "axi_lite_mem_config.svh"

module axi_mem_ctrl (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  axi_lite_mem_pkg::axi_req_t  req_i,
  output axi_lite_mem_pkg::axi_resp_t resp_o,
  input  axi_lite_mem_pkg::cfg_t      cfg_i,
  // one-cycle pulse per successful memory write
  output logic                        wr_done_o
);
  import axi_lite_mem_pkg::*;

  // word index taken from the whole byte address
  localparam int unsigned IDX_W = `AXI_ADDR_W - 2;

  data_t              mem_q [`MEM_WORDS];
  mem_state_e         st_q;
  logic [`WAIT_W-1:0] cnt_q;
  logic               is_wr_q;
  logic               wr_done_q;
  // captured response payload
  axi_resp_e          resp_q;
  data_t              rdata_q;
  logic [3:0]         id_q;

  logic [IDX_W-1:0] wr_idx, rd_idx;
  logic             wr_oor, wr_prot, rd_oor;
  logic             wr_go, rd_go, resp_hs;
  axi_resp_e        wr_resp;

  assign wr_idx  = req_i.aw.addr[`AXI_ADDR_W-1:2];
  assign rd_idx  = req_i.ar.addr[`AXI_ADDR_W-1:2];
  assign wr_oor  = wr_idx >= IDX_W'(`MEM_WORDS);
  assign rd_oor  = rd_idx >= IDX_W'(`MEM_WORDS);
  // protected from the base word upwards
  assign wr_prot = wr_idx >= IDX_W'(cfg_i.protect_base);

  // decode error outranks the protection check
  assign wr_resp = wr_oor ? RESP_DECERR : (wr_prot ? RESP_SLVERR : RESP_OKAY);

  // write needs AW and W together and wins over a pending read
  assign wr_go   = (st_q == ST_IDLE) & req_i.aw_valid & req_i.w_valid;
  assign rd_go   = (st_q == ST_IDLE) & req_i.ar_valid & ~wr_go;
  assign resp_hs = (st_q == ST_RESP) & (is_wr_q ? req_i.b_ready : req_i.r_ready);

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = wr_go;
    resp_o.w_ready  = wr_go;
    resp_o.ar_ready = rd_go;
    resp_o.b        = '{id: id_q, resp: resp_q};
    resp_o.b_valid  = (st_q == ST_RESP) & is_wr_q;
    resp_o.r        = '{id: id_q, data: rdata_q, resp: resp_q, last: 1'b1};
    resp_o.r_valid  = (st_q == ST_RESP) & ~is_wr_q;
  end

  assign wr_done_o = wr_done_q;

  // FSM, response follows acceptance by wait_states + 1 cycles
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      st_q      <= ST_IDLE;
      cnt_q     <= '0;
      is_wr_q   <= 1'b0;
      wr_done_q <= 1'b0;
    end else begin
      wr_done_q <= wr_go & (wr_resp == RESP_OKAY);
      case (st_q)
        ST_IDLE: begin
          if (wr_go || rd_go) begin
            is_wr_q <= wr_go;
            // wait count sampled here, later changes do not apply
            cnt_q   <= cfg_i.wait_states;
            st_q    <= (cfg_i.wait_states == '0) ? ST_RESP : ST_WAIT;
          end
        end
        ST_WAIT: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == `WAIT_W'(1)) begin
            st_q <= ST_RESP;
          end
        end
        ST_RESP: begin
          // held until the master takes it
          if (resp_hs) begin
            st_q <= ST_IDLE;
          end
        end
        default: st_q <= ST_IDLE;
      endcase
    end
  end

  // storage and response payload
  always_ff @(posedge clk_i) begin
    if (wr_go) begin
      id_q   <= req_i.aw.id;
      resp_q <= wr_resp;
      if (wr_resp == RESP_OKAY) begin
        for (int b = 0; b < $bits(strb_t); b++) begin
          if (req_i.w.strb[b]) begin
            mem_q[wr_idx[`MEM_IDX_W-1:0]][8*b +: 8] <= req_i.w.data[8*b +: 8];
          end
        end
      end
    end else if (rd_go) begin
      id_q    <= req_i.ar.id;
      resp_q  <= rd_oor ? RESP_DECERR : RESP_OKAY;
      // out-of-range reads return zero
      rdata_q <= rd_oor ? '0 : mem_q[rd_idx[`MEM_IDX_W-1:0]];
    end
  end

endmodule

// File: hdl/axi_addr_decode.sv
// AXI4 two-target address decoder
`timescale 1ns/100ps
`include "axi_lite_mem_config.svh"

module axi_addr_decode (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  // upstream master
  input  axi_lite_mem_pkg::axi_req_t  slv_req_i,
  output axi_lite_mem_pkg::axi_resp_t slv_resp_o,
  // memory controller target
  output axi_lite_mem_pkg::axi_req_t  mem_req_o,
  input  axi_lite_mem_pkg::axi_resp_t mem_resp_i,
  // configuration block target
  output axi_lite_mem_pkg::axi_req_t  cfg_req_o,
  input  axi_lite_mem_pkg::axi_resp_t cfg_resp_i
);
  import axi_lite_mem_pkg::*;

  // owner flags per direction, sel high means the config block
  logic w_busy_q, w_sel_q;
  logic r_busy_q, r_sel_q;

  // target chosen by the pending address
  logic aw_sel, ar_sel;

  // upstream handshakes that open or close ownership
  logic aw_hs, b_hs, ar_hs, r_hs;

  assign aw_sel = slv_req_i.aw.addr[`CFG_SEL_BIT];
  assign ar_sel = slv_req_i.ar.addr[`CFG_SEL_BIT];

  // payload goes to both targets, only the valids are steered
  always_comb begin
    mem_req_o = slv_req_i;
    cfg_req_o = slv_req_i;
    // new requests held off while the direction is owned
    mem_req_o.aw_valid = slv_req_i.aw_valid & ~w_busy_q & ~aw_sel;
    mem_req_o.w_valid  = slv_req_i.w_valid  & ~w_busy_q & ~aw_sel;
    cfg_req_o.aw_valid = slv_req_i.aw_valid & ~w_busy_q &  aw_sel;
    cfg_req_o.w_valid  = slv_req_i.w_valid  & ~w_busy_q &  aw_sel;
    mem_req_o.ar_valid = slv_req_i.ar_valid & ~r_busy_q & ~ar_sel;
    cfg_req_o.ar_valid = slv_req_i.ar_valid & ~r_busy_q &  ar_sel;
    // response readies only reach the owner
    mem_req_o.b_ready  = slv_req_i.b_ready & w_busy_q & ~w_sel_q;
    cfg_req_o.b_ready  = slv_req_i.b_ready & w_busy_q &  w_sel_q;
    mem_req_o.r_ready  = slv_req_i.r_ready & r_busy_q & ~r_sel_q;
    cfg_req_o.r_ready  = slv_req_i.r_ready & r_busy_q &  r_sel_q;
  end

  // readies from the addressed target, responses from the owner
  always_comb begin
    slv_resp_o          = '0;
    slv_resp_o.aw_ready = ~w_busy_q & (aw_sel ? cfg_resp_i.aw_ready : mem_resp_i.aw_ready);
    slv_resp_o.w_ready  = ~w_busy_q & (aw_sel ? cfg_resp_i.w_ready  : mem_resp_i.w_ready);
    slv_resp_o.ar_ready = ~r_busy_q & (ar_sel ? cfg_resp_i.ar_ready : mem_resp_i.ar_ready);
    slv_resp_o.b        = w_sel_q ? cfg_resp_i.b : mem_resp_i.b;
    slv_resp_o.b_valid  = w_busy_q & (w_sel_q ? cfg_resp_i.b_valid : mem_resp_i.b_valid);
    slv_resp_o.r        = r_sel_q ? cfg_resp_i.r : mem_resp_i.r;
    slv_resp_o.r_valid  = r_busy_q & (r_sel_q ? cfg_resp_i.r_valid : mem_resp_i.r_valid);
  end

  assign aw_hs = slv_req_i.aw_valid & slv_resp_o.aw_ready;
  assign b_hs  = slv_resp_o.b_valid & slv_req_i.b_ready;
  assign ar_hs = slv_req_i.ar_valid & slv_resp_o.ar_ready;
  assign r_hs  = slv_resp_o.r_valid & slv_req_i.r_ready;

  // ownership taken at acceptance, dropped after the response beat
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      w_busy_q <= 1'b0;
      w_sel_q  <= 1'b0;
      r_busy_q <= 1'b0;
      r_sel_q  <= 1'b0;
    end else begin
      if (aw_hs) begin
        w_busy_q <= 1'b1;
        w_sel_q  <= aw_sel;
      end else if (b_hs) begin
        w_busy_q <= 1'b0;
      end
      if (ar_hs) begin
        r_busy_q <= 1'b1;
        r_sel_q  <= ar_sel;
      end else if (r_hs) begin
        r_busy_q <= 1'b0;
      end
    end
  end

endmodule

// File: hdl/axi_lite_to_axi.sv
// AXI4-Lite to AXI4 adapter
`timescale 1ns/100ps

module axi_lite_to_axi (
  // lite side, from the external master
  input  axi_lite_mem_pkg::lite_req_t  slv_req_lite_i,
  output axi_lite_mem_pkg::lite_resp_t slv_resp_lite_o,
  // full AXI4 side, towards the decoder
  output axi_lite_mem_pkg::axi_req_t   mst_req_o,
  input  axi_lite_mem_pkg::axi_resp_t  mst_resp_i
);
  import axi_lite_mem_pkg::*;

  // every beat spans the whole data bus
  localparam logic [2:0] BEAT_SIZE = 3'($clog2($bits(data_t) / 8));

  // requests widened with id 0, single fixed beat
  assign mst_req_o = '{
    aw: '{
      id:    4'd0,
      addr:  slv_req_lite_i.aw.addr,
      len:   8'd0,
      size:  BEAT_SIZE,
      burst: BURST_FIXED,
      lock:  1'b0,
      cache: 4'd0,
      prot:  slv_req_lite_i.aw.prot
    },
    aw_valid: slv_req_lite_i.aw_valid,
    w: '{
      data: slv_req_lite_i.w.data,
      strb: slv_req_lite_i.w.strb,
      last: 1'b1
    },
    w_valid: slv_req_lite_i.w_valid,
    b_ready: slv_req_lite_i.b_ready,
    ar: '{
      id:    4'd0,
      addr:  slv_req_lite_i.ar.addr,
      len:   8'd0,
      size:  BEAT_SIZE,
      burst: BURST_FIXED,
      lock:  1'b0,
      cache: 4'd0,
      prot:  slv_req_lite_i.ar.prot
    },
    ar_valid: slv_req_lite_i.ar_valid,
    r_ready:  slv_req_lite_i.r_ready
  };

  // responses narrowed back, id and last dropped
  assign slv_resp_lite_o = '{
    aw_ready: mst_resp_i.aw_ready,
    w_ready:  mst_resp_i.w_ready,
    b:        '{resp: mst_resp_i.b.resp},
    b_valid:  mst_resp_i.b_valid,
    ar_ready: mst_resp_i.ar_ready,
    r:        '{data: mst_resp_i.r.data, resp: mst_resp_i.r.resp},
    r_valid:  mst_resp_i.r_valid
  };

endmodule

// File: hdl/axi_lite_mem_pkg.sv
// AXI-Lite memory types
`include "axi_lite_mem_config.svh"

package axi_lite_mem_pkg;

  // basic payload types
  typedef logic [`AXI_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_DATA_W-1:0]   data_t;
  typedef logic [`AXI_DATA_W/8-1:0] strb_t;

  // response encoding as on the bus
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // burst encoding, only fixed is produced here
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  // AXI4-Lite channels
  typedef struct packed {
    addr_t       addr;
    logic [2:0]  prot;
  } lite_ax_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } lite_w_t;

  typedef struct packed {
    axi_resp_e resp;
  } lite_b_t;

  typedef struct packed {
    data_t     data;
    axi_resp_e resp;
  } lite_r_t;

  typedef struct packed {
    lite_ax_t aw;
    logic     aw_valid;
    lite_w_t  w;
    logic     w_valid;
    logic     b_ready;
    lite_ax_t ar;
    logic     ar_valid;
    logic     r_ready;
  } lite_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    lite_b_t b;
    logic    b_valid;
    logic    ar_ready;
    lite_r_t r;
    logic    r_valid;
  } lite_resp_t;

  // AXI4 channels, reduced to single-beat fields
  typedef struct packed {
    logic [3:0] id;
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    axi_burst_e burst;
    logic       lock;
    logic [3:0] cache;
    logic [2:0] prot;
  } axi_ax_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    logic [3:0] id;
    axi_resp_e  resp;
  } axi_b_t;

  typedef struct packed {
    logic [3:0] id;
    data_t      data;
    axi_resp_e  resp;
    logic       last;
  } axi_r_t;

  typedef struct packed {
    axi_ax_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    logic    b_ready;
    axi_ax_t ar;
    logic    ar_valid;
    logic    r_ready;
  } axi_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    axi_b_t  b;
    logic    b_valid;
    logic    ar_ready;
    axi_r_t  r;
    logic    r_valid;
  } axi_resp_t;

  // memory controller FSM
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_WAIT = 2'b01,
    ST_RESP = 2'b10
  } mem_state_e;

  // settings handed from the config block to the controller
  typedef struct packed {
    logic [`WAIT_W-1:0]  wait_states;
    // one bit above the index so the full depth fits
    logic [`MEM_IDX_W:0] protect_base;
  } cfg_t;

endpackage

// File: hdl/axi_lite_mem_config.svh
// AXI-Lite memory configuration
`ifndef AXI_LITE_MEM_CONFIG_SVH
`define AXI_LITE_MEM_CONFIG_SVH

// bus geometry
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// memory depth in data words
`define MEM_WORDS 256
// bits of a word index into the memory
`define MEM_IDX_W 8

// address bit that steers a request to the configuration block
`define CFG_SEL_BIT 12

// width of the response wait-state count
`define WAIT_W 4

// configuration reset values
`define CFG_WAIT_RESET 2
// protect base at the top of memory, nothing protected
`define CFG_PROT_RESET `MEM_WORDS

`endif
